// File: Makefile
# Verilator build for the shared scratch memory

VERILATOR ?= verilator
FLIST     ?= shared_mem.f
TB_TOP    ?= shared_mem_tb
RTL_TOP   ?= shared_mem_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/shared_mem_chk.sv
////////////////////////////////////////////////////////////////////////////
// Protocol checker for the shared scratch memory
// Alert shape, response state around reset and violation count order
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module shared_mem_chk (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        clear,
	input  mem_access_pkg::mem_rsp_t    rsp1,
	input  mem_access_pkg::mem_rsp_t    rsp2,
	input  mem_status_pkg::mem_status_t status,
	input  logic                        alert
);

	// Number of failed assertions
	int fails = 0;

	// Alert is a single-cycle pulse
	alert_single: assert property (@(posedge clk) disable iff (!rst_n)
		alert |=> !alert)
		else begin
			$error("alert stayed high for two cycles");
			fails++;
		end

	// No response flags while in reset
	rsp_quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> !rsp1.valid && !rsp1.tainted && !rsp2.valid && !rsp2.tainted)
		else begin
			$error("response flags set during reset");
			fails++;
		end

	// Nor on the first edge after it
	rsp_quiet_after_reset: assert property (@(posedge clk)
		!rst_n |=> !rsp1.valid && !rsp1.tainted && !rsp2.valid && !rsp2.tainted)
		else begin
			$error("response flags set right after reset");
			fails++;
		end

	// Count only drops through clear
	count_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(clear) |-> status.count >= $past(status.count))
		else begin
			$error("violation count went down without clear");
			fails++;
		end

endmodule

bind shared_mem_top shared_mem_chk u_chk (.*);

`default_nettype wire

// File: bench/shared_mem_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the shared scratch memory
// Random and directed traffic against a reference model of both ports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "shared_mem_defs.svh"

module shared_mem_tb;

	import mem_access_pkg::*;
	import mem_status_pkg::*;

	// Reset, single port, collisions, ordering, hog, clear, saturation and drain,
	// clear with a violation and drain, reset again
	localparam int PLANNED_CYCLES = 5 + 80 + 32 + 36 + 20 + 2 + 262 + 6 + 2 + 4 + 10;
	localparam int CYCLE_LIMIT = PLANNED_CYCLES + 50;

	// Expected read tagged with the edge its response shows up at
	typedef struct packed {
		logic [31:0] due;
		logic        known;
		data_t       data;
	} exp_rd_t;

	logic        clk;
	logic        rst_n;
	logic        clear;
	logic        alert;
	mem_req_t    req1;
	mem_req_t    req2;
	mem_rsp_t    rsp1;
	mem_rsp_t    rsp2;
	mem_status_t status;

	// Reference model state
	data_t       ref_mem [0:(1 << `SM_AW) - 1];
	logic        ref_known [0:(1 << `SM_AW) - 1];
	logic        viol_hist [0:1023];
	exp_rd_t     q1[$];
	exp_rd_t     q2[$];
	mem_req_t    prev1;
	mem_req_t    prev2;
	logic        def_wr;
	logic        def_rd;
	addr_t       def_addr;
	data_t       def_data;
	viol_vec_t   exp_sticky;
	viol_cnt_t   exp_count;
	logic        exp_alert;
	int unsigned edge_n;
	int          rsp_errs;
	int          status_errs;
	int          alert_errs;
	int          cycles;

	shared_mem_top dut0 (
		.clk    (clk),
		.rst_n  (rst_n),
		.req1   (req1),
		.req2   (req2),
		.clear  (clear),
		.rsp1   (rsp1),
		.rsp2   (rsp2),
		.status (status),
		.alert  (alert)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic mem_req_t write_req(input addr_t a, input data_t d);
		mem_req_t r;
		r      = '0;
		r.wen  = 1'b1;
		r.addr = a;
		r.din  = d;
		return r;
	endfunction

	function automatic mem_req_t read_req(input addr_t a);
		mem_req_t r;
		r      = '0;
		r.ren  = 1'b1;
		r.addr = a;
		return r;
	endfunction

	// Only the low half of the array holds checked data
	// Hog traffic stays above it
	function automatic exp_rd_t expect_read(input addr_t a, input int unsigned due);
		exp_rd_t e;
		e.due   = due;
		e.known = !a[`SM_AW-1] && ref_known[a];
		e.data  = ref_mem[a];
		return e;
	endfunction

	// Present one cycle of requests, sampled on the next edge
	task automatic drive(input mem_req_t r1, input mem_req_t r2, input logic clr);
		req1  = r1;
		req2  = r2;
		clear = clr;
		@(posedge clk);
		#2;
	endtask

	// Compare one port's response with the head of its queue
	task automatic check_rsp(input int port, input mem_rsp_t rsp, input logic hit,
			input exp_rd_t e, input int lat);
		logic t;
		t = hit && (viol_hist[(e.due - lat) % 1024] || viol_hist[(e.due - lat + 1) % 1024]);
		assert (rsp.valid == hit && rsp.tainted == t) else begin
			$display("CHECK FAILED at %0t: port %0d valid %b tainted %b, expected %b %b",
				$time, port, rsp.valid, rsp.tainted, hit, t);
			rsp_errs++;
		end
		if (hit && e.known && !t) begin
			assert (rsp.dout == e.data) else begin
				$display("CHECK FAILED at %0t: port %0d data %h, expected %h",
					$time, port, rsp.dout, e.data);
				rsp_errs++;
			end
		end
	endtask

	// Reference model, checks first and then takes this edge's requests
	always @(posedge clk) begin
		viol_vec_t v;
		exp_rd_t   e1;
		exp_rd_t   e2;
		logic      hit1;
		logic      hit2;
		if (!rst_n) begin
			prev1      = '0;
			prev2      = '0;
			def_wr     = 1'b0;
			def_rd     = 1'b0;
			exp_sticky = '0;
			exp_count  = '0;
			exp_alert  = 1'b0;
			q1.delete();
			q2.delete();
			viol_hist[edge_n % 1024] = 1'b0;
		end else begin
			hit1 = q1.size() > 0 && q1[0].due == edge_n;
			hit2 = q2.size() > 0 && q2[0].due == edge_n;
			e1   = '0;
			e2   = '0;
			if (hit1) e1 = q1.pop_front();
			if (hit2) e2 = q2.pop_front();
			check_rsp(1, rsp1, hit1, e1, 2);
			check_rsp(2, rsp2, hit2, e2, 3);
			assert (status.sticky == exp_sticky && status.count == exp_count) else begin
				$display("CHECK FAILED at %0t: status %h/%0d, expected %h/%0d",
					$time, status.sticky, status.count, exp_sticky, exp_count);
				status_errs++;
			end
			assert (alert == exp_alert) else begin
				$display("CHECK FAILED at %0t: alert %b, expected %b", $time, alert, exp_alert);
				alert_errs++;
			end
			// Hog rules
			v           = '0;
			v[VK_P1_WR] = req1.wen && prev1.wen;
			v[VK_P1_RD] = req1.ren && prev1.ren;
			v[VK_P2_WR] = req2.wen && prev2.wen;
			v[VK_P2_RD] = req2.ren && prev2.ren;
			viol_hist[edge_n % 1024] = |v;
			exp_alert = |(v & ~exp_sticky);
			if (clear) begin
				exp_sticky = v;
				exp_count  = (|v) ? viol_cnt_t'(1) : '0;
			end else begin
				exp_sticky = exp_sticky | v;
				if (|v && exp_count != '1) exp_count = exp_count + 1'b1;
			end
			// Reads see the array before this edge's writes
			if (def_rd) q2.push_back(expect_read(def_addr, edge_n + 2));
			if (req1.ren) q1.push_back(expect_read(req1.addr, edge_n + 2));
			if (req2.ren && !req1.ren) q2.push_back(expect_read(req2.addr, edge_n + 3));
			if (def_wr) begin
				ref_mem[def_addr]   = def_data;
				ref_known[def_addr] = 1'b1;
			end
			if (req1.wen) begin
				ref_mem[req1.addr]   = req1.din;
				ref_known[req1.addr] = 1'b1;
			end
			if (req2.wen && !req1.wen) begin
				ref_mem[req2.addr]   = req2.din;
				ref_known[req2.addr] = 1'b1;
			end
			// Port 2 loses a collision and goes one cycle later
			def_rd   = req1.ren && req2.ren;
			def_wr   = req1.wen && req2.wen;
			def_addr = req2.addr;
			def_data = req2.din;
			prev1    = req1;
			prev2    = req2;
		end
		edge_n++;
	end

	// Watchdog
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int       i;
		addr_t    a;
		data_t    d;
		mem_req_t r;
		void'($urandom(32'h0724_76bb));
		req1        = '0;
		req2        = '0;
		clear       = 1'b0;
		rst_n       = 1'b0;
		edge_n      = 0;
		rsp_errs    = 0;
		status_errs = 0;
		alert_errs  = 0;
		for (i = 0; i < (1 << `SM_AW); i++) ref_known[i] = 1'b0;
		repeat (5) @(posedge clk);
		#2 rst_n = 1'b1;
		// One port at a time, never back to back
		for (i = 0; i < 40; i++) begin
			a = addr_t'($urandom_range(15));
			d = data_t'($urandom);
			r = (i < 8 || $urandom_range(1) == 0) ? write_req(a, d) : read_req(a);
			if ($urandom_range(1) == 1) drive(r, '0, 1'b0);
			else drive('0, r, 1'b0);
			drive('0, '0, 1'b0);
		end
		// Both ports in the same cycle
		for (i = 0; i < 8; i++) begin
			a = addr_t'(32 + 2 * i);
			drive(write_req(a, data_t'($urandom)), write_req(a + addr_t'(1), data_t'($urandom)),
				1'b0);
			drive('0, '0, 1'b0);
			drive(read_req(a + addr_t'(1)), read_req(a), 1'b0);
			drive('0, '0, 1'b0);
		end
		// Write then cross-port read, and same-cycle read of old data
		for (i = 0; i < 4; i++) begin
			a = addr_t'(64 + i);
			drive(write_req(a, data_t'($urandom)), '0, 1'b0);
			drive('0, read_req(a), 1'b0);
			drive('0, write_req(a, data_t'($urandom)), 1'b0);
			drive(read_req(a), '0, 1'b0);
			drive('0, '0, 1'b0);
			drive(read_req(a), write_req(a, data_t'($urandom)), 1'b0);
			drive('0, '0, 1'b0);
			drive(write_req(a, data_t'($urandom)), read_req(a), 1'b0);
			drive('0, '0, 1'b0);
		end
		// Each hog rule once with tainted reads around the violations
		drive(write_req(300, 8'h11), '0, 1'b0);
		drive(write_req(301, 8'h22), '0, 1'b0);
		drive('0, '0, 1'b0);
		drive(read_req(300), '0, 1'b0);
		drive(read_req(301), '0, 1'b0);
		drive('0, '0, 1'b0);
		drive('0, write_req(302, 8'h33), 1'b0);
		drive('0, write_req(303, 8'h44), 1'b0);
		drive('0, '0, 1'b0);
		drive('0, read_req(302), 1'b0);
		drive('0, read_req(303), 1'b0);
		drive('0, '0, 1'b0);
		drive(write_req(310, 8'h55), read_req(311), 1'b0);
		drive(write_req(311, 8'h66), '0, 1'b0);
		repeat (6) drive('0, '0, 1'b0);
		// Clear and then saturate the count
		drive('0, '0, 1'b1);
		drive('0, '0, 1'b0);
		for (i = 0; i < 262; i++) drive(write_req(320, data_t'(i)), '0, 1'b0);
		repeat (6) drive('0, '0, 1'b0);
		// Violation on the clear cycle survives it
		drive(write_req(320, 8'h01), '0, 1'b0);
		drive(write_req(321, 8'h02), '0, 1'b1);
		repeat (4) drive('0, '0, 1'b0);
		// Reset in the middle of the run
		rst_n = 1'b0;
		repeat (5) drive('0, '0, 1'b0);
		rst_n = 1'b1;
		repeat (5) drive('0, '0, 1'b0);
		$display("Errors: response %0d, status %0d, alert %0d, protocol %0d",
			rsp_errs, status_errs, alert_errs, dut0.u_chk.fails);
		if (rsp_errs + status_errs + alert_errs + dut0.u_chk.fails == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: include/shared_mem_defs.svh
////////////////////////////////////////////////////////////////////////////
// Shared scratch memory widths
// Address, data and violation counter sizes for every block
////////////////////////////////////////////////////////////////////////////

`ifndef SHARED_MEM_DEFS_SVH
`define SHARED_MEM_DEFS_SVH

// Word address, 512 words deep
`define SM_AW 9

// Data word width
`define SM_DW 8

// Saturating violation counter
`define SM_CNT_W 8

`endif

// File: rtl/fake_dpram.sv
////////////////////////////////////////////////////////////////////////////
// Two request ports on one simple dual-port RAM
// Port 1 always wins, port 2 collisions are deferred by one cycle
// Read latency is 1 cycle on port 1 and a fixed 2 cycles on port 2
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fake_dpram (
	input  logic                     clk,
	input  logic                     rst_n,
	// Client requests, single-cycle strobes
	input  mem_access_pkg::mem_req_t req1,
	input  mem_access_pkg::mem_req_t req2,
	// Port 1 read data, one cycle after the request
	output mem_access_pkg::data_t    rd1,
	output logic                     rd1_valid,
	// Port 2 read data, two cycles after the request
	output mem_access_pkg::data_t    rd2,
	output logic                     rd2_valid
);

	import mem_access_pkg::*;

	// One-cycle copies of the request strobes
	logic wen1_d;
	logic ren1_d;
	logic wen2_d;
	logic ren2_d;
	// Two-cycle copies steer the port 2 data path
	logic ren1_dd;
	logic ren2_dd;
	// Port 2 payload held for a deferred access
	addr_t addr2_d;
	data_t din2_d;
	// RAM side
	addr_t ram_wr_addr;
	data_t ram_wr_data;
	logic  ram_wen;
	addr_t ram_rd_addr;
	data_t ram_q;
	data_t ram_q_d;

	// Strobe history, cleared so nothing deferred runs after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wen1_d  <= 1'b0;
			ren1_d  <= 1'b0;
			wen2_d  <= 1'b0;
			ren2_d  <= 1'b0;
			ren1_dd <= 1'b0;
			ren2_dd <= 1'b0;
		end else begin
			wen1_d  <= req1.wen;
			ren1_d  <= req1.ren;
			wen2_d  <= req2.wen;
			ren2_d  <= req2.ren;
			ren1_dd <= ren1_d;
			ren2_dd <= ren2_d;
		end
	end

	// Port 2 address and data, plus the second RAM output stage
	always_ff @(posedge clk) begin
		addr2_d <= req2.addr;
		din2_d  <= req2.din;
		ram_q_d <= ram_q;
	end

	// Write slot: port 1, then port 2, then the deferred port 2 write
	// A deferred write only exists after a write-write collision
	always_comb begin
		if (req1.wen) begin
			ram_wr_addr = req1.addr;
			ram_wr_data = req1.din;
		end else if (req2.wen) begin
			ram_wr_addr = req2.addr;
			ram_wr_data = req2.din;
		end else begin
			ram_wr_addr = addr2_d;
			ram_wr_data = din2_d;
		end
	end

	assign ram_wen = req1.wen | req2.wen | (wen1_d & wen2_d);

	// Read slot in the same order
	// Falls to the held port 2 address when nobody reads,
	// which is exactly the deferred read after a read-read collision
	always_comb begin
		if (req1.ren) begin
			ram_rd_addr = req1.addr;
		end else if (req2.ren) begin
			ram_rd_addr = req2.addr;
		end else begin
			ram_rd_addr = addr2_d;
		end
	end

	simple_dpram u_ram (
		.clk     (clk),
		.wr_addr (ram_wr_addr),
		.wr_data (ram_wr_data),
		.wen     (ram_wen),
		.rd_addr (ram_rd_addr),
		.rd_data (ram_q)
	);

	// Port 1 reads straight off the RAM register
	assign rd1       = ram_q;
	assign rd1_valid = ren1_d;

	// Port 2: deferred reads come straight off the RAM a cycle late,
	// undisturbed reads take the extra register to line up
	assign rd2       = ren1_dd ? ram_q : ram_q_d;
	assign rd2_valid = ren2_dd;

endmodule

`default_nettype wire

// File: rtl/hog_monitor.sv
////////////////////////////////////////////////////////////////////////////
// Bus hog monitor
// Flags back-to-back requests per port and kind, latches and counts them
// and marks reads whose data a violation may have spoiled
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hog_monitor (
	input  logic                        clk,
	input  logic                        rst_n,
	input  mem_access_pkg::mem_req_t    req1,
	input  mem_access_pkg::mem_req_t    req2,
	// Drops the sticky flags and the count
	input  logic                        clear,
	// Rules broken in this cycle
	output mem_status_pkg::viol_vec_t   viol,
	output mem_status_pkg::mem_status_t status,
	// Taint, lined up with rd1_valid and rd2_valid
	output logic                        taint1,
	output logic                        taint2
);

	import mem_status_pkg::*;

	// Own copy of the previous cycle's strobes
	logic      wen1_d;
	logic      ren1_d;
	logic      wen2_d;
	logic      ren2_d;
	// Violation history for the taint window
	logic      viol_any;
	logic      viol_any_d;
	viol_vec_t sticky_q;
	viol_cnt_t count_q;
	logic      taint2_q;

	// Same kind on the same port in two cycles running
	always_comb begin
		viol           = '0;
		viol[VK_P1_WR] = req1.wen & wen1_d;
		viol[VK_P1_RD] = req1.ren & ren1_d;
		viol[VK_P2_WR] = req2.wen & wen2_d;
		viol[VK_P2_RD] = req2.ren & ren2_d;
	end

	assign viol_any = |viol;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wen1_d     <= 1'b0;
			ren1_d     <= 1'b0;
			wen2_d     <= 1'b0;
			ren2_d     <= 1'b0;
			viol_any_d <= 1'b0;
			sticky_q   <= '0;
			count_q    <= '0;
			taint2_q   <= 1'b0;
		end else begin
			wen1_d     <= req1.wen;
			ren1_d     <= req1.ren;
			wen2_d     <= req2.wen;
			ren2_d     <= req2.ren;
			viol_any_d <= viol_any;
			// A violation on the clear cycle survives it
			if (clear) begin
				sticky_q <= viol;
				count_q  <= viol_any ? viol_cnt_t'(1) : '0;
			end else begin
				sticky_q <= sticky_q | viol;
				// Holds at all ones
				if (viol_any && count_q != '1) begin
					count_q <= count_q + 1'b1;
				end
			end
			// Port 2 read from last cycle, violation then or now
			taint2_q <= ren2_d & (viol_any_d | viol_any);
		end
	end

	// Port 1 read from last cycle, violation then or now
	assign taint1 = ren1_d & (viol_any_d | viol_any);
	assign taint2 = taint2_q;

	assign status = '{sticky: sticky_q, count: count_q};

endmodule

`default_nettype wire

// File: rtl/mem_access_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Memory access types
// Addresses, data words and the per-port request and response records
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "shared_mem_defs.svh"

package mem_access_pkg;

	// Word address into the shared array
	typedef logic [`SM_AW-1:0] addr_t;

	// One data word
	typedef logic [`SM_DW-1:0] data_t;

	// One client request, a single-cycle strobe
	// Both wen and ren may be set in the same cycle
	typedef struct packed {
		logic  wen;
		logic  ren;
		addr_t addr;
		data_t din;
	} mem_req_t;

	// Registered read response seen by a client
	// tainted marks data that a rule violation may have spoiled
	typedef struct packed {
		logic  valid;
		logic  tainted;
		data_t dout;
	} mem_rsp_t;

endpackage

`default_nettype wire

// File: rtl/mem_status_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Memory status types
// Bus hog rule kinds, their flag vector and the status summary
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "shared_mem_defs.svh"

package mem_status_pkg;

	// Index of each no-hogging rule in a viol_vec_t
	typedef enum logic [1:0] {
		VK_P1_WR = 2'd0,
		VK_P1_RD = 2'd1,
		VK_P2_WR = 2'd2,
		VK_P2_RD = 2'd3
	} viol_kind_e;

	// One flag per rule
	typedef logic [3:0] viol_vec_t;

	// Violating cycles seen, holds at all ones
	typedef logic [`SM_CNT_W-1:0] viol_cnt_t;

	// Summary presented to the outside
	typedef struct packed {
		viol_vec_t sticky;
		viol_cnt_t count;
	} mem_status_t;

endpackage

`default_nettype wire

// File: rtl/resp_merge.sv
////////////////////////////////////////////////////////////////////////////
// Response stage
// Registers read data with its taint into one response per port
// and pulses alert when a rule is broken for the first time
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module resp_merge (
	input  logic                      clk,
	input  logic                      rst_n,
	// From the storage block
	input  mem_access_pkg::data_t     rd1,
	input  mem_access_pkg::data_t     rd2,
	input  logic                      rd1_valid,
	input  logic                      rd2_valid,
	// From the monitor
	input  logic                      taint1,
	input  logic                      taint2,
	input  mem_status_pkg::viol_vec_t viol,
	input  mem_status_pkg::viol_vec_t sticky,
	// To the clients
	output mem_access_pkg::mem_rsp_t  rsp1,
	output mem_access_pkg::mem_rsp_t  rsp2,
	output logic                      alert
);

	import mem_access_pkg::*;
	import mem_status_pkg::*;

	// Control bits of both responses
	logic      valid1_q;
	logic      valid2_q;
	logic      taint1_q;
	logic      taint2_q;
	// Read data payload
	data_t     dout1_q;
	data_t     dout2_q;
	// Rules broken now that were not flagged yet
	viol_vec_t fresh;
	logic      alert_q;

	assign fresh = viol & ~sticky;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid1_q <= 1'b0;
			valid2_q <= 1'b0;
			taint1_q <= 1'b0;
			taint2_q <= 1'b0;
			alert_q  <= 1'b0;
		end else begin
			valid1_q <= rd1_valid;
			valid2_q <= rd2_valid;
			// Taint only travels with a real read
			taint1_q <= rd1_valid & taint1;
			taint2_q <= rd2_valid & taint2;
			alert_q  <= |fresh;
		end
	end

	always_ff @(posedge clk) begin
		dout1_q <= rd1;
		dout2_q <= rd2;
	end

	assign rsp1 = '{valid: valid1_q, tainted: taint1_q, dout: dout1_q};
	assign rsp2 = '{valid: valid2_q, tainted: taint2_q, dout: dout2_q};

	assign alert = alert_q;

endmodule

`default_nettype wire

// File: rtl/shared_mem_top.sv
////////////////////////////////////////////////////////////////////////////
// Shared scratch memory for two clients
// Storage and hog monitor run side by side, the response stage joins them
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module shared_mem_top (
	input  logic                        clk,
	input  logic                        rst_n,
	// Client requests
	input  mem_access_pkg::mem_req_t    req1,
	input  mem_access_pkg::mem_req_t    req2,
	// Drops the violation status
	input  logic                        clear,
	// Port 1 after 2 cycles, port 2 after 3
	output mem_access_pkg::mem_rsp_t    rsp1,
	output mem_access_pkg::mem_rsp_t    rsp2,
	output mem_status_pkg::mem_status_t status,
	output logic                        alert
);

	import mem_access_pkg::*;
	import mem_status_pkg::*;

	// Storage to response stage
	data_t     rd1;
	data_t     rd2;
	logic      rd1_valid;
	logic      rd2_valid;
	// Monitor to response stage
	logic      taint1;
	logic      taint2;
	viol_vec_t viol;

	// Both blocks see the same request edge
	fake_dpram u_store (
		.clk       (clk),
		.rst_n     (rst_n),
		.req1      (req1),
		.req2      (req2),
		.rd1       (rd1),
		.rd2       (rd2),
		.rd1_valid (rd1_valid),
		.rd2_valid (rd2_valid)
	);

	hog_monitor u_mon (
		.clk    (clk),
		.rst_n  (rst_n),
		.req1   (req1),
		.req2   (req2),
		.clear  (clear),
		.viol   (viol),
		.status (status),
		.taint1 (taint1),
		.taint2 (taint2)
	);

	// Sticky flags come back from the status output
	resp_merge u_rsp (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd1       (rd1),
		.rd2       (rd2),
		.rd1_valid (rd1_valid),
		.rd2_valid (rd2_valid),
		.taint1    (taint1),
		.taint2    (taint2),
		.viol      (viol),
		.sticky    (status.sticky),
		.rsp1      (rsp1),
		.rsp2      (rsp2),
		.alert     (alert)
	);

endmodule

`default_nettype wire

// File: rtl/simple_dpram.sv
////////////////////////////////////////////////////////////////////////////
// Simple dual-port RAM
// One write port and one read port, read registered every cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "shared_mem_defs.svh"

module simple_dpram (
	input  logic                  clk,
	// Write port
	input  mem_access_pkg::addr_t wr_addr,
	input  mem_access_pkg::data_t wr_data,
	input  logic                  wen,
	// Read port, no enable
	input  mem_access_pkg::addr_t rd_addr,
	output mem_access_pkg::data_t rd_data
);

	import mem_access_pkg::*;

	// Storage array, contents undefined until written
	data_t mem [0:(1 << `SM_AW) - 1];

	// Old data wins on a same-word read and write
	// since both sides use the array value before the edge
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[wr_addr] <= wr_data;
		end
		// Read runs every cycle whether anyone wants it or not
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: shared_mem.f
+incdir+include
rtl/mem_access_pkg.sv
rtl/mem_status_pkg.sv
rtl/simple_dpram.sv
rtl/fake_dpram.sv
rtl/hog_monitor.sv
rtl/resp_merge.sv
rtl/shared_mem_top.sv
bench/shared_mem_chk.sv
bench/shared_mem_tb.sv
